//--- verilog/dbg_pkg.sv
`default_nettype none

package dbg_pkg;

	localparam int FRAME_BITS = 144;                    // payload + address + direction
	localparam logic [14:0] BROADCAST_ADDR = 15'h7fff;  // reset address and enumeration target

	// direction bit, lsb of the frame
	typedef enum logic {
		DIR_READ  = 1'b0,                               // node replaces the payload
		DIR_WRITE = 1'b1                                // node latches the payload
	} dbg_dir_e;

	// read command, low byte of the payload
	typedef enum logic [7:0] {
		RCMD_IDENT = 8'h00                              // anything else returns outgoing data
	} dbg_rcmd_e;

	// wire order, msb goes out first
	typedef struct packed {
		logic [127:0] payload;                          // frame bits 143..16
		logic [14:0]  addr;                             // frame bits 15..1
		dbg_dir_e     dir;                              // frame bit 0
	} dbg_frame_t;

endpackage

`default_nettype wire

//--- verilog/dbg_line_sync.sv
`timescale 1ns/1ps
`default_nettype none

module dbg_line_sync (
	input  wire  clk,
	input  wire  rst_n,
	input  logic line_clk,                      // upstream line clock, idles high
	input  logic line_data,                     // upstream line data
	output logic bit_data,                      // synced data, aligned with rise
	output logic rise,                          // one-cycle pulse on line clock rising
	output logic fall                           // one-cycle pulse on line clock falling
);

	logic clk_s1, clk_s2;                       // line clock sync stages
	logic data_s1, data_s2;                     // line data sync stages
	logic clk_prev;                             // last synced clock level

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			clk_s1   <= 1'b1;                   // matches idle line, no false edge
			clk_s2   <= 1'b1;
			clk_prev <= 1'b1;
			data_s1  <= 1'b0;
			data_s2  <= 1'b0;
			bit_data <= 1'b0;
			rise     <= 1'b0;
			fall     <= 1'b0;
		end else begin
			clk_s1   <= line_clk;
			clk_s2   <= clk_s1;
			clk_prev <= clk_s2;
			data_s1  <= line_data;
			data_s2  <= data_s1;
			bit_data <= data_s2;                // third stage keeps data in step with the pulses
			rise     <= clk_s2 & ~clk_prev;     // low to high
			fall     <= ~clk_s2 & clk_prev;     // high to low
		end
	end

endmodule

`default_nettype wire

//--- verilog/dbg_frame_tx.sv
`timescale 1ns/1ps
`default_nettype none

module dbg_frame_tx import dbg_pkg::*; #(
	parameter int PRESCALE = 2                  // clk cycles per line clock half period
) (
	input  wire        clk,
	input  wire        rst_n,
	input  logic       start,                   // load frame and begin, ignored while busy
	input  dbg_frame_t frame,                   // frame to send
	output logic       line_clk,                // line clock, idles high
	output logic       line_data,               // changes on the falling edge
	output logic       busy                     // high until the line is back idle
);

	localparam int HCW = $clog2(PRESCALE + 1);  // half period counter width
	localparam int BCW = $clog2(FRAME_BITS + 1);

	logic [FRAME_BITS-1:0] shreg;               // outgoing bits, msb first
	logic [HCW-1:0]        half_cnt;            // cycles left in this half period
	logic [BCW-1:0]        bit_cnt;             // bits still to put on the line

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			line_clk  <= 1'b1;
			line_data <= 1'b0;
			busy      <= 1'b0;
			half_cnt  <= '0;
			bit_cnt   <= '0;
		end else if (!busy) begin
			if (start) begin
				busy     <= 1'b1;
				half_cnt <= HCW'(PRESCALE - 1); // lead-in high phase before the first fall
				bit_cnt  <= BCW'(FRAME_BITS);
			end
		end else if (half_cnt != '0) begin
			half_cnt <= half_cnt - 1'b1;        // hold the current phase
		end else begin
			half_cnt <= HCW'(PRESCALE - 1);
			if (!line_clk) begin
				line_clk <= 1'b1;               // receivers sample here
			end else if (bit_cnt == '0) begin
				busy <= 1'b0;                   // last high half done, line stays high
			end else begin
				line_clk  <= 1'b0;
				line_data <= shreg[FRAME_BITS-1];
				bit_cnt   <= bit_cnt - 1'b1;
			end
		end
	end

	// frame shift register, msb feeds the line
	always_ff @(posedge clk) begin
		if (!busy && start) begin
			shreg <= frame;
		end else if (busy && half_cnt == '0 && line_clk && bit_cnt != '0) begin
			shreg <= {shreg[FRAME_BITS-2:0], 1'b0}; // next bit up to the msb
		end
	end

	// an idle serializer must leave the line clock high
	a_idle_high: assert property (@(posedge clk) disable iff (!rst_n)
		!busy |-> line_clk)
		else $error("line clock low while serializer idle");

endmodule

`default_nettype wire

//--- verilog/dbg_node.sv
`timescale 1ns/1ps
`default_nettype none

module dbg_node import dbg_pkg::*; #(
	parameter int           PRESCALE = 2,      // line clock half period in clk cycles
	parameter logic [127:0] IDENTITY = '0      // returned for an ident read
) (
	input  wire           clk,
	input  wire           rst_n,
	input  logic          rx_clk,              // from upstream stage
	input  logic          rx_data,
	output logic          tx_clk,              // to downstream stage
	output logic          tx_data,
	input  logic [127:0]  outgoing_data,       // returned for any other read
	output logic [127:0]  incoming_data,       // last written payload
	output logic          incoming_tgl         // flips on each write
);

	localparam int BCW = $clog2(FRAME_BITS + 1);

	typedef enum logic [1:0] {
		ST_IDLE,                                // wait for the first falling edge
		ST_LOAD,                                // shift in on rising edges
		ST_DECODE,                              // one cycle edit of the frame
		ST_SEND                                 // serializer forwards the frame
	} state_e;

	state_e         state;
	dbg_frame_t     frame_q;                    // store and forward buffer
	logic [14:0]    node_addr;                  // set by enumeration
	logic [BCW-1:0] bit_cnt;                    // bits still to receive
	logic           tx_start;                   // one-cycle start into the serializer
	logic           tx_busy;
	logic           rx_bit, rx_rise, rx_fall;

	dbg_line_sync u_rx (
		.clk       (clk),
		.rst_n     (rst_n),
		.line_clk  (rx_clk),
		.line_data (rx_data),
		.bit_data  (rx_bit),
		.rise      (rx_rise),
		.fall      (rx_fall)
	);

	dbg_frame_tx #(.PRESCALE(PRESCALE)) u_tx (
		.clk       (clk),
		.rst_n     (rst_n),
		.start     (tx_start),
		.frame     (frame_q),
		.line_clk  (tx_clk),
		.line_data (tx_data),
		.busy      (tx_busy)
	);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state         <= ST_IDLE;
			node_addr     <= BROADCAST_ADDR;
			bit_cnt       <= '0;
			tx_start      <= 1'b0;
			incoming_data <= '0;
			incoming_tgl  <= 1'b0;
		end else begin
			tx_start <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (rx_fall) begin
						state   <= ST_LOAD;
						bit_cnt <= BCW'(FRAME_BITS);
					end
				end
				ST_LOAD: begin
					if (rx_rise) begin
						bit_cnt <= bit_cnt - 1'b1;
						if (bit_cnt == BCW'(1))
							state <= ST_DECODE; // 144th bit is in
					end
				end
				ST_DECODE: begin
					state    <= ST_SEND;
					tx_start <= 1'b1;           // forward starts next cycle
					if (node_addr == BROADCAST_ADDR && frame_q.addr == BROADCAST_ADDR) begin
						node_addr <= frame_q.payload[14:0];
					end else if (frame_q.addr == node_addr && frame_q.dir == DIR_WRITE) begin
						incoming_data <= frame_q.payload;
						incoming_tgl  <= ~incoming_tgl;
					end
				end
				ST_SEND: begin
					if (!tx_start && !tx_busy)
						state <= ST_IDLE;       // busy rises one cycle after start
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// frame buffer, shifted in on rises and edited in decode
	always_ff @(posedge clk) begin
		if (state == ST_LOAD && rx_rise) begin
			frame_q <= dbg_frame_t'({frame_q[FRAME_BITS-2:0], rx_bit});
		end else if (state == ST_DECODE) begin
			if (node_addr == BROADCAST_ADDR && frame_q.addr == BROADCAST_ADDR) begin
				frame_q.payload[14:0] <= frame_q.payload[14:0] + 15'd1; // next node's address
			end else if (frame_q.addr == node_addr && frame_q.dir == DIR_READ) begin
				if (frame_q.payload[7:0] == RCMD_IDENT)
					frame_q.payload <= IDENTITY;
				else
					frame_q.payload <= outgoing_data;
			end
		end
	end

	// the toggle only moves on a decoded write
	a_tgl_in_decode: assert property (@(posedge clk) disable iff (!rst_n)
		$changed(incoming_tgl) |-> $past(state == ST_DECODE))
		else $error("incoming_tgl changed outside decode");

	// one frame in the ring, so upstream is quiet while we forward
	a_no_rx_while_send: assert property (@(posedge clk) disable iff (!rst_n)
		state == ST_SEND |-> !rx_rise)
		else $error("line clock rise while node is sending");

endmodule

`default_nettype wire

//--- verilog/dbg_host.sv
`timescale 1ns/1ps
`default_nettype none

module dbg_host import dbg_pkg::*; #(
	parameter int PRESCALE = 2                  // line clock half period in clk cycles
) (
	input  wire        clk,
	input  wire        rst_n,
	input  logic       cmd_valid,               // command strobe, dropped while busy
	input  dbg_frame_t cmd,
	output logic       busy,                    // a frame is out on the ring
	output logic       tx_clk,                  // to node 0
	output logic       tx_data,
	input  logic       rx_clk,                  // from the last node
	input  logic       rx_data,
	output logic       rsp_valid,               // one cycle, frame is back
	output dbg_frame_t rsp
);

	localparam int BCW = $clog2(FRAME_BITS + 1);

	typedef enum logic [1:0] {
		ST_IDLE,                                // ready for a command
		ST_SEND,                                // serializer running
		ST_WAIT                                 // waiting for and collecting the return
	} state_e;

	state_e         state;
	dbg_frame_t     rx_frame;                   // returned frame being assembled
	logic [BCW-1:0] bit_cnt;                    // zero means armed, not yet started
	logic           tx_start;
	logic           tx_busy;
	logic           rx_bit, rx_rise, rx_fall;

	assign tx_start = cmd_valid && state == ST_IDLE;
	assign busy     = state != ST_IDLE;
	assign rsp      = rx_frame;                 // held until the next frame arrives

	dbg_frame_tx #(.PRESCALE(PRESCALE)) u_tx (
		.clk       (clk),
		.rst_n     (rst_n),
		.start     (tx_start),
		.frame     (cmd),
		.line_clk  (tx_clk),
		.line_data (tx_data),
		.busy      (tx_busy)
	);

	dbg_line_sync u_rx (
		.clk       (clk),
		.rst_n     (rst_n),
		.line_clk  (rx_clk),
		.line_data (rx_data),
		.bit_data  (rx_bit),
		.rise      (rx_rise),
		.fall      (rx_fall)
	);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state     <= ST_IDLE;
			bit_cnt   <= '0;
			rsp_valid <= 1'b0;
		end else begin
			rsp_valid <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (cmd_valid)
						state <= ST_SEND;
				end
				ST_SEND: begin
					if (!tx_busy) begin
						state   <= ST_WAIT;     // our frame is fully on the line
						bit_cnt <= '0;
					end
				end
				ST_WAIT: begin
					if (bit_cnt == '0) begin
						if (rx_fall)
							bit_cnt <= BCW'(FRAME_BITS); // frame is coming back
					end else if (rx_rise) begin
						bit_cnt <= bit_cnt - 1'b1;
						if (bit_cnt == BCW'(1)) begin
							rsp_valid <= 1'b1;
							state     <= ST_IDLE;
						end
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == ST_WAIT && bit_cnt != '0 && rx_rise)
			rx_frame <= dbg_frame_t'({rx_frame[FRAME_BITS-2:0], rx_bit});
	end

	a_rsp_single: assert property (@(posedge clk) disable iff (!rst_n)
		rsp_valid |=> !rsp_valid)
		else $error("rsp_valid held for two cycles");

endmodule

`default_nettype wire

//--- verilog/dbg_ring_top.sv
`timescale 1ns/1ps
`default_nettype none

module dbg_ring_top import dbg_pkg::*; #(
	parameter int                    NODES       = 4,  // ring length
	parameter int                    PRESCALE    = 2,  // min 2
	parameter logic [NODES*128-1:0]  NODE_IDENTS = '0  // slice i is node i's identity
) (
	input  wire                   clk,
	input  wire                   rst_n,
	input  logic                  cmd_valid,
	input  dbg_frame_t            cmd,
	output logic                  busy,
	output logic                  rsp_valid,
	output dbg_frame_t            rsp,
	input  logic [NODES*128-1:0]  outgoing_data,
	output logic [NODES*128-1:0]  incoming_data,
	output logic [NODES-1:0]      incoming_tgl
);

	// link i feeds stage i, link NODES closes the loop to the host
	logic [NODES:0] ring_clk;
	logic [NODES:0] ring_data;

	dbg_host #(.PRESCALE(PRESCALE)) u_host (
		.clk       (clk),
		.rst_n     (rst_n),
		.cmd_valid (cmd_valid),
		.cmd       (cmd),
		.busy      (busy),
		.tx_clk    (ring_clk[0]),
		.tx_data   (ring_data[0]),
		.rx_clk    (ring_clk[NODES]),
		.rx_data   (ring_data[NODES]),
		.rsp_valid (rsp_valid),
		.rsp       (rsp)
	);

	for (genvar i = 0; i < NODES; i++) begin : g_node
		dbg_node #(
			.PRESCALE (PRESCALE),
			.IDENTITY (NODE_IDENTS[i*128 +: 128])
		) u_node (
			.clk           (clk),
			.rst_n         (rst_n),
			.rx_clk        (ring_clk[i]),
			.rx_data       (ring_data[i]),
			.tx_clk        (ring_clk[i+1]),
			.tx_data       (ring_data[i+1]),
			.outgoing_data (outgoing_data[i*128 +: 128]),
			.incoming_data (incoming_data[i*128 +: 128]),
			.incoming_tgl  (incoming_tgl[i])
		);
	end

endmodule

`default_nettype wire

//--- tb/dbg_ring_tb.sv
`timescale 1ns/1ps
`default_nettype none

module dbg_ring_tb import dbg_pkg::*; ();

	localparam int NODES    = 4;
	localparam int PRESCALE = 2;
	localparam int N_DATA   = 6;                // random data reads
	localparam int N_WRITE  = 6;                // random writes
	localparam int N_UNASGN = 3;                // frames to nobody
	localparam int TXNS     = 1 + NODES + N_DATA + N_WRITE + N_UNASGN;
	localparam int WD_CYCLES = TXNS * (NODES + 1) * (288 * PRESCALE + 32) * 2;

	// node 3 down to node 0
	localparam logic [NODES*128-1:0] NODE_IDENTS = {
		128'h3c91_e7a4_05bd_6f28_d4e0_19c7_a253_8b6f,
		128'h7e02_b5d9_c14a_3f86_0a7b_e2d1_59c4_f630,
		128'hd86b_2a1f_94e3_70c5_b1d8_4e2a_c7f9_0365,
		128'h15af_c3e8_6d72_9b04_f8a1_3e5c_d2b7_4a90
	};

	logic                 clk;
	logic                 rst_n;
	logic                 cmd_valid;
	dbg_frame_t           cmd;
	logic                 busy;
	logic                 rsp_valid;
	dbg_frame_t           rsp;
	logic [NODES*128-1:0] outgoing_data;
	logic [NODES*128-1:0] incoming_data;
	logic [NODES-1:0]     incoming_tgl;

	// ring model state per node
	logic [14:0]  m_addr [NODES];
	logic [127:0] m_in   [NODES];
	logic         m_tgl  [NODES];

	int errors  = 0;
	int checks  = 0;
	int tests   = 0;
	int err_at_start;                           // error count when the current test began

	dbg_ring_top #(
		.NODES       (NODES),
		.PRESCALE    (PRESCALE),
		.NODE_IDENTS (NODE_IDENTS)
	) u_dbg_ring_top (
		.clk           (clk),
		.rst_n         (rst_n),
		.cmd_valid     (cmd_valid),
		.cmd           (cmd),
		.busy          (busy),
		.rsp_valid     (rsp_valid),
		.rsp           (rsp),
		.outgoing_data (outgoing_data),
		.incoming_data (incoming_data),
		.incoming_tgl  (incoming_tgl)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;                 // 20 ns period
	end

	initial begin
		repeat (WD_CYCLES + 5) @(posedge clk);
		$display("watchdog: the ring hung, no response after %0d cycles", WD_CYCLES);
		$display("Done: errors found");
		$finish;
	end

	function automatic logic [127:0] rand128();
		return {$urandom, $urandom, $urandom, $urandom};
	endfunction

	task automatic check(input logic [143:0] got, input logic [143:0] exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %0t ns: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic end_test(input string name);
		tests++;
		if (errors == err_at_start)
			$display("test %s: pass", name);
		else
			$display("test %s: %0d errors", name, errors - err_at_start);
		err_at_start = errors;
	endtask

	// walks the frame through every node in ring order
	task automatic model_ring(inout dbg_frame_t f);
		for (int i = 0; i < NODES; i++) begin
			if (m_addr[i] == BROADCAST_ADDR && f.addr == BROADCAST_ADDR) begin
				m_addr[i] = f.payload[14:0];    // node keeps what it got
				f.payload[14:0] = f.payload[14:0] + 15'd1;
			end else if (f.addr == m_addr[i] && f.dir == DIR_READ) begin
				if (f.payload[7:0] == 8'h00)
					f.payload = NODE_IDENTS[i*128 +: 128];
				else
					f.payload = outgoing_data[i*128 +: 128];
			end else if (f.addr == m_addr[i] && f.dir == DIR_WRITE) begin
				m_in[i]  = f.payload;
				m_tgl[i] = ~m_tgl[i];           // frame itself goes on unchanged
			end
		end
	endtask

	task automatic check_nodes();
		for (int i = 0; i < NODES; i++) begin
			check(incoming_data[i*128 +: 128], m_in[i], $sformatf("node %0d incoming_data", i));
			check(incoming_tgl[i], m_tgl[i], $sformatf("node %0d incoming_tgl", i));
		end
	endtask

	// strobe a command once the host is free, then collect the return
	task automatic send_frame(input dbg_frame_t f, output dbg_frame_t got);
		@(negedge clk);
		while (busy)
			@(negedge clk);
		cmd_valid = 1'b1;
		cmd       = f;
		@(negedge clk);
		cmd_valid = 1'b0;
		while (!rsp_valid)
			@(negedge clk);
		got = rsp;                              // stable mid-cycle
	endtask

	task automatic run_txn(input dbg_frame_t f, input string what, output dbg_frame_t got);
		dbg_frame_t exp;
		exp = f;
		model_ring(exp);
		send_frame(f, got);
		check(got, exp, {what, " frame"});
		check_nodes();
	endtask

	initial begin
		int unsigned seed;
		dbg_frame_t  f;
		dbg_frame_t  got;
		logic [127:0] p;
		seed = 32'h86aa5582;
		void'($urandom(seed));
		rst_n     = 1'b0;
		cmd_valid = 1'b0;
		cmd       = '0;
		for (int i = 0; i < NODES; i++) begin
			outgoing_data[i*128 +: 128] = rand128();
			m_addr[i] = BROADCAST_ADDR;         // reset address
			m_in[i]   = '0;
			m_tgl[i]  = 1'b0;
		end
		err_at_start = 0;
		repeat (5) @(negedge clk);
		rst_n = 1'b1;

		check(busy, 1'b0, "busy after reset");
		check(rsp_valid, 1'b0, "rsp_valid after reset");
		check_nodes();
		end_test("reset");

		p = rand128();
		f.payload = {p[127:15], 15'd0};         // first node takes address 0
		f.addr    = BROADCAST_ADDR;
		f.dir     = dbg_dir_e'($urandom_range(1, 0));
		run_txn(f, "enumeration", got);
		check(got.payload[14:0], 15'(NODES), "enumeration end address");
		end_test("enumeration");

		for (int i = 0; i < NODES; i++) begin
			p = rand128();
			p[7:0] = RCMD_IDENT;
			f.payload = p;
			f.addr    = 15'(i);
			f.dir     = DIR_READ;
			run_txn(f, $sformatf("ident read node %0d", i), got);
			check(got.payload, NODE_IDENTS[i*128 +: 128], $sformatf("identity of node %0d", i));
		end
		end_test("identity read");

		for (int n = 0; n < N_DATA; n++) begin
			p = rand128();
			p[7:0] = 8'($urandom_range(255, 1));   // anything but ident
			f.payload = p;
			f.addr    = 15'($urandom_range(NODES - 1, 0));
			f.dir     = DIR_READ;
			run_txn(f, "data read", got);
		end
		end_test("data read");

		for (int n = 0; n < N_WRITE; n++) begin
			f.payload = rand128();
			f.addr    = 15'($urandom_range(NODES - 1, 0));
			f.dir     = DIR_WRITE;
			run_txn(f, "write", got);
			check(got, f, "write returned verbatim");
		end
		end_test("write");

		for (int n = 0; n < N_UNASGN; n++) begin
			f.payload = rand128();
			f.addr    = 15'($urandom_range(15'h7ffe, NODES));   // below broadcast
			f.dir     = dbg_dir_e'($urandom_range(1, 0));
			run_txn(f, "unassigned address", got);
			check(got, f, "unassigned returned verbatim");
		end
		end_test("unassigned address");

		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

`default_nettype wire

//--- all.f
verilog/dbg_pkg.sv
verilog/dbg_line_sync.sv
verilog/dbg_frame_tx.sv
verilog/dbg_node.sv
verilog/dbg_host.sv
verilog/dbg_ring_top.sv
tb/dbg_ring_tb.sv
